/* Makefile */
# Verilator flow for the UART testbench

TOP := uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TEST PASSED" > /dev/null

clean:
	rm -rf obj_dir

/* rtl/uart_frame_pkg.sv */
/*
 * Serial frame format for the UART
 * Byte and bit index types, frame length, TX and RX state encodings
 */
`default_nettype none

package uart_frame_pkg;

  localparam int DATA_BITS = 8;
  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // Start bit, 8 data bits, one stop bit and no parity
  localparam int FRAME_BITS = 10;
  typedef logic [FRAME_BITS-1:0] frame_t;

  // Position in a frame: 0 start, 1 to 8 data, 9 stop
  typedef logic [3:0] bit_idx_t;

  localparam bit_idx_t STOP_IDX = bit_idx_t'(FRAME_BITS - 1);
  localparam bit_idx_t LAST_DATA_IDX = bit_idx_t'(DATA_BITS);

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
/*
 * UART receiver with input synchronizer and start-bit glitch filter
 * Samples mid-bit and checks the stop bit
 */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      rx_i,
  output uart_frame_pkg::uart_byte_t data_o,
  output logic                      valid_o,
  output logic                      frame_err_o
);

  localparam uart_timing_pkg::bit_cnt_t BIT_LAST =
    uart_timing_pkg::bit_cnt_t'(uart_timing_pkg::CLKS_PER_BIT - 1);
  localparam uart_timing_pkg::bit_cnt_t HALF_LAST =
    uart_timing_pkg::bit_cnt_t'(uart_timing_pkg::HALF_BIT - 1);

  logic rx_meta_q;
  logic rx_sync_q;

  uart_frame_pkg::rx_state_e  state_q;
  uart_frame_pkg::uart_byte_t shift_q;
  uart_timing_pkg::bit_cnt_t  cnt_q;
  uart_frame_pkg::bit_idx_t   idx_q;

  // Two-flop synchronizer that idles high like the line
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  // Data bits enter at the top so the first one ends up as the LSB
  always_ff @(posedge clk_i) begin
    if (state_q == uart_frame_pkg::RX_DATA && cnt_q == BIT_LAST) begin
      shift_q <= {rx_sync_q, shift_q[uart_frame_pkg::DATA_BITS-1:1]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= uart_frame_pkg::RX_IDLE;
      cnt_q       <= '0;
      idx_q       <= '0;
      data_o      <= '0;
      valid_o     <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      valid_o     <= 1'b0;
      frame_err_o <= 1'b0;
      case (state_q)
        uart_frame_pkg::RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_sync_q) begin
            state_q <= uart_frame_pkg::RX_START;
          end
        end

        uart_frame_pkg::RX_START: begin
          if (cnt_q == HALF_LAST) begin
            cnt_q <= '0;
            // First data bit sits at frame position 1
            idx_q <= uart_frame_pkg::bit_idx_t'(1);
            // High again at mid-bit means a glitch
            state_q <= rx_sync_q ? uart_frame_pkg::RX_IDLE : uart_frame_pkg::RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        uart_frame_pkg::RX_DATA: begin
          if (cnt_q == BIT_LAST) begin
            cnt_q <= '0;
            idx_q <= idx_q + 1'b1;
            if (idx_q == uart_frame_pkg::LAST_DATA_IDX) begin
              state_q <= uart_frame_pkg::RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        uart_frame_pkg::RX_STOP: begin
          if (cnt_q == BIT_LAST) begin
            cnt_q   <= '0;
            state_q <= uart_frame_pkg::RX_IDLE;
            if (rx_sync_q) begin
              data_o  <= shift_q;
              valid_o <= 1'b1;
            end else begin
              frame_err_o <= 1'b1;   // old byte stays on data_o
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        default: begin
          state_q <= uart_frame_pkg::RX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_timing_pkg.sv */
/*
 * Bit timing constants and counter types for the UART
 * Also sizes the transmit FIFO and its pointers
 */
`default_nettype none

package uart_timing_pkg;

  // Clock cycles per serial bit, kept small for fast simulation
  // Must stay even and at least 4
  localparam int CLKS_PER_BIT = 16;

  // Sample point inside the start bit
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

  // Transmit FIFO size in bytes, power of two so pointers wrap naturally
  localparam int TX_FIFO_DEPTH = 4;

  localparam int FIFO_PTR_W = $clog2(TX_FIFO_DEPTH);
  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  // Fill level needs one more bit to reach TX_FIFO_DEPTH
  typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

endpackage

`default_nettype wire

/* rtl/uart_top.sv */
/*
 * UART top level with transmit FIFO, transmitter and receiver
 */
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Host transmit side
  input  uart_frame_pkg::uart_byte_t tx_data_i,
  input  logic                      tx_write_i,
  output logic                      tx_full_o,
  // Serial lines
  output logic                      tx_o,
  input  logic                      rx_i,
  // Host receive side
  output uart_frame_pkg::uart_byte_t rx_data_o,
  output logic                      rx_valid_o,
  output logic                      rx_frame_err_o
);

  uart_frame_pkg::uart_byte_t fifo_rd_data;
  logic                       fifo_empty;
  logic                       fifo_pop;

  uart_tx_fifo u_tx_fifo (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (tx_write_i),
    .wr_data_i (tx_data_i),
    .pop_i     (fifo_pop),
    .rd_data_o (fifo_rd_data),
    .empty_o   (fifo_empty),
    .full_o    (tx_full_o)
  );

  uart_tx u_tx (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .empty_i (fifo_empty),
    .data_i  (fifo_rd_data),
    .pop_o   (fifo_pop),
    .tx_o    (tx_o)
  );

  // Receive path runs on its own, no shared state with TX
  uart_rx u_rx (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_i        (rx_i),
    .data_o      (rx_data_o),
    .valid_o     (rx_valid_o),
    .frame_err_o (rx_frame_err_o)
  );

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
/*
 * UART transmitter, pops one FIFO byte per frame
 * Sends start, data LSB first and stop bit
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      empty_i,
  input  uart_frame_pkg::uart_byte_t data_i,
  output logic                      pop_o,
  output logic                      tx_o
);

  localparam uart_timing_pkg::bit_cnt_t BIT_LAST =
    uart_timing_pkg::bit_cnt_t'(uart_timing_pkg::CLKS_PER_BIT - 1);

  uart_frame_pkg::tx_state_e state_q;
  uart_frame_pkg::frame_t    shift_q;
  uart_timing_pkg::bit_cnt_t cnt_q;
  uart_frame_pkg::bit_idx_t  idx_q;

  logic bit_end;

  // Take the head byte as soon as the line is free
  assign pop_o   = (state_q == uart_frame_pkg::TX_IDLE) && !empty_i;
  assign bit_end = (cnt_q == BIT_LAST);

  // Bit 0 of the shift register is the line, ones fill in from the top
  assign tx_o = shift_q[0];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= uart_frame_pkg::TX_IDLE;
      shift_q <= '1;
      cnt_q   <= '0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        uart_frame_pkg::TX_IDLE: begin
          if (pop_o) begin
            // Stop, data and start, so the start bit leaves first
            shift_q <= {1'b1, data_i, 1'b0};
            cnt_q   <= '0;
            idx_q   <= '0;
            state_q <= uart_frame_pkg::TX_SEND;
          end
        end

        uart_frame_pkg::TX_SEND: begin
          if (bit_end) begin
            cnt_q <= '0;
            if (idx_q == uart_frame_pkg::STOP_IDX) begin
              // Stop bit done, line already sits high
              state_q <= uart_frame_pkg::TX_IDLE;
            end else begin
              shift_q <= {1'b1, shift_q[uart_frame_pkg::FRAME_BITS-1:1]};
              idx_q   <= idx_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end

        default: begin
          state_q <= uart_frame_pkg::TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/uart_tx_fifo.sv */
/*
 * Transmit FIFO holding bytes queued by the host
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      wr_i,
  input  uart_frame_pkg::uart_byte_t wr_data_i,
  input  logic                      pop_i,
  output uart_frame_pkg::uart_byte_t rd_data_o,
  output logic                      empty_o,
  output logic                      full_o
);

  uart_frame_pkg::uart_byte_t mem_q [uart_timing_pkg::TX_FIFO_DEPTH];

  uart_timing_pkg::fifo_ptr_t wr_ptr_q;
  uart_timing_pkg::fifo_ptr_t rd_ptr_q;
  uart_timing_pkg::fifo_cnt_t count_q;

  logic do_write;
  logic do_pop;

  // Writes into a full FIFO and pops from an empty one are dropped
  assign do_write = wr_i && !full_o;
  assign do_pop   = pop_i && !empty_o;

  assign empty_o   = (count_q == '0);
  assign full_o    = (count_q == uart_timing_pkg::fifo_cnt_t'(uart_timing_pkg::TX_FIFO_DEPTH));
  assign rd_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous write and pop leave the level unchanged
      if (do_write && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_write) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/clk_rst_gen.sv */
/*
 * Testbench clock and reset source, 20 ns period, two-cycle reset
 */
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    // Release away from the active edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* verif/uart_tb.sv */
/*
 * UART testbench with random bytes, serial loopback and a queue model
 * Covers reset, TX format, loopback, back-pressure, frame error, glitch
 */
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

  localparam int FRAME_CLKS = 10 * uart_timing_pkg::CLKS_PER_BIT;
  localparam int LIMIT = 8 * FRAME_CLKS;

  logic clk, rst_n, tx_write, tx_full, tx_line, rx_line, drv_line, loopback;
  logic rx_valid, rx_frame_err;
  uart_frame_pkg::uart_byte_t tx_data, rx_data, last, b;
  uart_frame_pkg::uart_byte_t tx_q[$];
  uart_frame_pkg::uart_byte_t rx_q[$];
  integer seed;
  logic [31:0] rnd;
  int errors, valid_cnt, ferr_cnt, dropped, vb, fb, k, t;

  clk_rst_gen clk_rst_gen (.clk_o(clk), .rst_no(rst_n));

  // Serial input is either the DUT's own output or a driven line
  assign rx_line = loopback ? tx_line : drv_line;

  uart_top DUT (
    .clk_i(clk), .rst_ni(rst_n), .tx_data_i(tx_data), .tx_write_i(tx_write),
    .tx_full_o(tx_full), .tx_o(tx_line), .rx_i(rx_line), .rx_data_o(rx_data),
    .rx_valid_o(rx_valid), .rx_frame_err_o(rx_frame_err)
  );

  task automatic check_equal(input string name, input int expected, input int actual);
    assert (expected == actual) else begin
      errors++;
      $display("FAIL %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
    end
  endtask

  // Sets one strobe, which the FIFO takes only when not full
  task automatic write_byte(input uart_frame_pkg::uart_byte_t d, input bit wait_room);
    int w;
    w = 0;
    @(negedge clk);
    while (wait_room && tx_full && w < LIMIT) begin
      tx_write = 1'b0;
      @(negedge clk);
      w++;
    end
    assert (!(wait_room && tx_full)) else begin
      errors++;
      $display("Timed out waiting for room in the TX FIFO");
    end
    tx_write = 1'b1;
    tx_data  = d;
    if (tx_full) dropped++;
    else if (loopback) rx_q.push_back(d);
    else tx_q.push_back(d);
  endtask

  task automatic end_write();
    @(negedge clk);
    tx_write = 1'b0;
  endtask

  // Finds the start edge on tx_o and samples every bit at its middle
  task automatic watch_frame(input string name);
    uart_frame_pkg::uart_byte_t got;
    int w;
    int i;
    w = 0;
    while (tx_line && w < LIMIT) begin
      @(negedge clk);
      w++;
    end
    assert (!tx_line) else begin
      errors++;
      $display("No start bit seen on tx_o during %s", name);
    end
    if (tx_line) begin
      tx_q.delete();
    end else begin
      repeat (uart_timing_pkg::HALF_BIT) @(negedge clk);
      check_equal({name, " start bit"}, 0, int'(tx_line));
      for (i = 0; i < 8; i++) begin
        repeat (uart_timing_pkg::CLKS_PER_BIT) @(negedge clk);
        got[i] = tx_line;
      end
      repeat (uart_timing_pkg::CLKS_PER_BIT) @(negedge clk);
      check_equal({name, " stop bit"}, 1, int'(tx_line));
      assert (tx_q.size() > 0) else begin
        errors++;
        $display("A frame left tx_o with no byte queued");
      end
      if (tx_q.size() > 0) check_equal({name, " data"}, int'(tx_q.pop_front()), int'(got));
    end
  endtask

  // Drives one frame bit by bit and then an idle gap of two bits
  task automatic drive_frame(input uart_frame_pkg::uart_byte_t d, input logic stop);
    logic [9:0] bits;
    int i;
    bits = {stop, d, 1'b0};
    @(negedge clk);
    for (i = 0; i < 10; i++) begin
      drv_line = bits[i];
      repeat (uart_timing_pkg::CLKS_PER_BIT) @(negedge clk);
    end
    drv_line = 1'b1;
    repeat (2 * uart_timing_pkg::CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic wait_rx(input int valid_goal, input int ferr_goal);
    int w;
    w = 0;
    while ((valid_cnt < valid_goal || ferr_cnt < ferr_goal) && w < LIMIT) begin
      @(negedge clk);
      w++;
    end
    assert (valid_cnt >= valid_goal && ferr_cnt >= ferr_goal) else begin
      errors++;
      $display("Timed out waiting for a pulse from the receiver");
    end
  endtask

  // Every good byte from the receiver must match the model
  always @(negedge clk) begin
    if (rst_n && rx_valid) begin
      valid_cnt++;
      assert (rx_q.size() > 0) else begin
        errors++;
        $display("rx_valid_o pulsed when no byte was expected");
      end
      if (rx_q.size() > 0) check_equal("rx data", int'(rx_q.pop_front()), int'(rx_data));
    end
    if (rst_n && rx_frame_err) ferr_cnt++;
  end

  initial begin
    seed = 32'hc650_577a;
    tx_data = '0;
    tx_write = 1'b0;
    drv_line = 1'b1;
    loopback = 1'b0;
    t = 0;
    while (rst_n !== 1'b1 && t < 10) begin
      @(negedge clk);
      t++;
    end
    assert (rst_n === 1'b1) else begin
      errors++;
      $display("Timed out waiting for the end of reset");
    end
    check_equal("reset tx_o", 1, int'(tx_line));
    check_equal("reset tx_full_o", 0, int'(tx_full));
    repeat (2 * FRAME_CLKS) @(negedge clk);
    check_equal("reset rx pulses", 0, valid_cnt + ferr_cnt);

    for (k = 0; k < 20; k++) begin
      rnd = $random(seed);
      write_byte(rnd[7:0], 1'b1);
      end_write();
      watch_frame("serial format");
    end

    loopback = 1'b1;
    vb = valid_cnt;
    for (k = 0; k < 30; k++) begin
      rnd = $random(seed);
      write_byte(rnd[7:0], 1'b1);
    end
    end_write();
    wait_rx(vb + 30, 0);
    check_equal("loopback bytes", 30, valid_cnt - vb);
    loopback = 1'b0;

    dropped = 0;
    fork
      begin
        for (k = 0; k < uart_timing_pkg::TX_FIFO_DEPTH + 2; k++) begin
          rnd = $random(seed);
          write_byte(rnd[7:0], 1'b0);
        end
        end_write();
      end
      watch_frame("back-pressure");
    join
    check_equal("back-pressure drop seen", 1, int'(dropped > 0));
    while (tx_q.size() > 0) watch_frame("back-pressure");
    repeat (uart_timing_pkg::CLKS_PER_BIT) @(negedge clk);
    check_equal("back-pressure idle line", 1, int'(tx_line));

    // No frame error may occur before bad frames are driven
    check_equal("frame errors before frame test", 0, ferr_cnt);

    // Frames with a low stop bit must leave the held byte alone
    last = rx_data;
    vb = valid_cnt;
    fb = ferr_cnt;
    for (k = 0; k < 3; k++) begin
      rnd = $random(seed);
      drive_frame(rnd[7:0], 1'b0);
      wait_rx(vb, fb + k + 1);
      check_equal("frame error count", k + 1, ferr_cnt - fb);
    end
    check_equal("frame error valid count", 0, valid_cnt - vb);
    check_equal("frame error rx data", int'(last), int'(rx_data));

    @(negedge clk);
    drv_line = 1'b0;
    repeat (uart_timing_pkg::HALF_BIT - 3) @(negedge clk);
    drv_line = 1'b1;
    repeat (2 * FRAME_CLKS) @(negedge clk);
    check_equal("glitch rx pulses", 0, valid_cnt - vb + ferr_cnt - fb - 3);
    rnd = $random(seed);
    b = rnd[7:0];
    rx_q.push_back(b);
    drive_frame(b, 1'b1);
    wait_rx(vb + 1, fb + 3);
    check_equal("glitch then good frame", 0, rx_q.size());

    $display("Done: %0d errors, %0d rx bytes, %0d frame errors", errors, valid_cnt, ferr_cnt);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/uart_timing_pkg.sv
rtl/uart_frame_pkg.sv
rtl/uart_tx_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verif/clk_rst_gen.sv
verif/uart_tb.sv
